//--- project.f
+incdir+verif
hdl/fetch_pkg.sv
hdl/fetch_fifo.sv
hdl/fetch_buf_ctrl.sv
hdl/fetch_buffer.sv
verif/fetch_buffer_tb.sv

//--- Bender.yml
package:
  name: fetch_buffer

sources:
  # RTL in compile order
  - files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_fifo.sv
      - hdl/fetch_buf_ctrl.sv
      - hdl/fetch_buffer.sv
  # testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fetch_buffer_tb.sv

//--- verif/fetch_tb_table.svh
`ifndef FETCH_TB_TABLE_SVH
`define FETCH_TB_TABLE_SVH

// columns: rnd | fifo_readygo fifo_ready flush | valid allowin nearly_full space_ok
// levels are the ones seen while the row is driven, before its clock edge
// rnd rows draw their strobes at random and take expected levels from the model
localparam int TABLE_ROWS = 49;

logic [7:0] stim_table [TABLE_ROWS] = '{
    // out of reset, single push, then pop it back out
    8'b0_000_0101,
    8'b0_100_0101,
    8'b0_000_1101,
    8'b0_010_1101,
    8'b0_000_0101,
    // fill to four, then a fifth readygo while full
    8'b0_100_0101,
    8'b0_100_1101,
    8'b0_100_1101,
    8'b0_100_1110,
    8'b0_100_1000,
    8'b0_000_1000,
    // both strobes when full pop only
    8'b0_110_1000,
    // push and pop together hold the count
    8'b0_110_1110,
    8'b0_010_1110,
    8'b0_010_1101,
    8'b0_110_1101,
    8'b0_010_1101,
    // pop on empty does nothing
    8'b0_010_0101,
    // flush with readygo in the same cycle
    8'b0_100_0101,
    8'b0_100_1101,
    8'b0_101_1101,
    8'b0_000_0101,
    // flush against a pop
    8'b0_100_0101,
    8'b0_011_1101,
    8'b0_000_0101,
    // random mix
    8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80,
    8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80,
    8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80,
    8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80
};

`endif

//--- verif/fetch_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_tb;

    `include "fetch_tb_table.svh"

    localparam int          CLK_PERIOD  = 4;
    localparam int          MAX_CYCLES  = TABLE_ROWS + 20;
    localparam int          QUEUE_DEPTH = 4;
    localparam logic [31:0] RESET_PC    = 32'h1c00_0000;
    localparam logic [31:0] NOP_INST    = 32'h0340_0000;

    typedef struct packed {
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] badv;
        logic        taken;
        logic [6:0]  excp;
        logic [1:0]  xflag;
        logic [1:0]  priv;
        logic [1:0]  br;
    } pkt_t;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        fifo_readygo;
    logic        fifo_ready;
    logic [1:0]  priv_flag;
    logic [1:0]  branch_flag;
    logic [31:0] if1_inst0;
    logic [31:0] if1_inst1;
    logic [31:0] if1_pc;
    logic [31:0] if1_pc_next;
    logic        if1_pc_taken;
    logic [31:0] if1_badv;
    logic [6:0]  if1_exception;
    logic [1:0]  if1_excp_flag;
    logic        write_en;
    logic        pop_en;
    logic        fifo_allowin;
    logic        fifo_valid;
    logic        nearly_full;
    logic        space_ok;
    logic [31:0] fifo_inst0;
    logic [31:0] fifo_inst1;
    logic [31:0] fifo_pc;
    logic [31:0] fifo_pc_add;
    logic [31:0] fifo_pc_next;
    logic [31:0] fifo_badv;
    logic        fifo_pc_taken;
    logic [6:0]  fifo_exception;
    logic [1:0]  fifo_excp_flag;
    logic [1:0]  fifo_priv_flag;
    logic [1:0]  fifo_branch_flag;

    // packets currently held with the head at index 0
    pkt_t model_q [$];
    int   cycle_cnt = 0;

    fetch_buffer dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .fifo_readygo     (fifo_readygo),
        .fifo_ready       (fifo_ready),
        .priv_flag        (priv_flag),
        .branch_flag      (branch_flag),
        .if1_inst0        (if1_inst0),
        .if1_inst1        (if1_inst1),
        .if1_pc           (if1_pc),
        .if1_pc_next      (if1_pc_next),
        .if1_pc_taken     (if1_pc_taken),
        .if1_badv         (if1_badv),
        .if1_exception    (if1_exception),
        .if1_excp_flag    (if1_excp_flag),
        .write_en         (write_en),
        .pop_en           (pop_en),
        .fifo_allowin     (fifo_allowin),
        .fifo_valid       (fifo_valid),
        .nearly_full      (nearly_full),
        .space_ok         (space_ok),
        .fifo_inst0       (fifo_inst0),
        .fifo_inst1       (fifo_inst1),
        .fifo_pc          (fifo_pc),
        .fifo_pc_add      (fifo_pc_add),
        .fifo_pc_next     (fifo_pc_next),
        .fifo_badv        (fifo_badv),
        .fifo_pc_taken    (fifo_pc_taken),
        .fifo_exception   (fifo_exception),
        .fifo_excp_flag   (fifo_excp_flag),
        .fifo_priv_flag   (fifo_priv_flag),
        .fifo_branch_flag (fifo_branch_flag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            abort_run();
        end
    endtask

    function automatic pkt_t random_packet();
        pkt_t p;
        p.inst0   = $urandom;
        p.inst1   = $urandom;
        p.pc      = $urandom;
        p.pc_next = $urandom;
        p.badv    = $urandom;
        p.taken   = 1'($urandom);
        p.excp    = 7'($urandom);
        p.xflag   = 2'($urandom);
        p.priv    = 2'($urandom);
        p.br      = 2'($urandom);
        return p;
    endfunction

    // empty buffer shows a nop pair at the reset pc
    function automatic pkt_t expected_head();
        pkt_t p;
        if (model_q.size() > 0) begin
            p = model_q[0];
        end else begin
            p = '0;
            p.inst0   = NOP_INST;
            p.inst1   = NOP_INST;
            p.pc      = RESET_PC;
            p.pc_next = RESET_PC + 32'd8;
            p.badv    = RESET_PC;
        end
        return p;
    endfunction

    task automatic apply_inputs(input logic rg, input logic rd, input logic fl,
                                input pkt_t p);
        fifo_readygo  = rg;
        fifo_ready    = rd;
        flush         = fl;
        if1_inst0     = p.inst0;
        if1_inst1     = p.inst1;
        if1_pc        = p.pc;
        if1_pc_next   = p.pc_next;
        if1_badv      = p.badv;
        if1_pc_taken  = p.taken;
        if1_exception = p.excp;
        if1_excp_flag = p.xflag;
        priv_flag     = p.priv;
        branch_flag   = p.br;
    endtask

    task automatic check_head();
        pkt_t e;
        e = expected_head();
        check_value("fifo_inst0", fifo_inst0, e.inst0);
        check_value("fifo_inst1", fifo_inst1, e.inst1);
        check_value("fifo_pc", fifo_pc, e.pc);
        check_value("fifo_pc_add", fifo_pc_add, e.pc + 32'd4);
        check_value("fifo_pc_next", fifo_pc_next, e.pc_next);
        check_value("fifo_badv", fifo_badv, e.badv);
        check_value("fifo_pc_taken", fifo_pc_taken, e.taken);
        check_value("fifo_exception", fifo_exception, e.excp);
        check_value("fifo_excp_flag", fifo_excp_flag, e.xflag);
        check_value("fifo_priv_flag", fifo_priv_flag, e.priv);
        check_value("fifo_branch_flag", fifo_branch_flag, e.br);
    endtask

    initial begin
        logic [7:0] row;
        logic       rg;
        logic       rd;
        logic       fl;
        logic       exp_push;
        logic       exp_pop;
        pkt_t       pkt;
        int         cnt;
        void'($urandom(32'h2daf_8157));
        rst_n = 1'b0;
        apply_inputs(1'b0, 1'b0, 1'b0, '0);
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < TABLE_ROWS; i++) begin
            @(posedge clk);
            #1;
            row = stim_table[i];
            if (row[7]) begin
                rg = ($urandom % 4) != 0;
                rd = ($urandom % 2) != 0;
                fl = ($urandom % 10) == 0;
            end else begin
                rg = row[6];
                rd = row[5];
                fl = row[4];
            end
            pkt = random_packet();
            apply_inputs(rg, rd, fl, pkt);
            // sample just before the next edge
            #2;
            cnt      = model_q.size();
            exp_push = rg && (cnt < QUEUE_DEPTH);
            exp_pop  = rd && (cnt > 0);
            if (!row[7]) begin
                check_value("fifo_valid (table)", fifo_valid, row[3]);
                check_value("fifo_allowin (table)", fifo_allowin, row[2]);
                check_value("nearly_full (table)", nearly_full, row[1]);
                check_value("space_ok (table)", space_ok, row[0]);
            end
            check_value("write_en", write_en, exp_push);
            check_value("pop_en", pop_en, exp_pop);
            check_value("fifo_valid", fifo_valid, cnt > 0);
            check_value("fifo_allowin", fifo_allowin, cnt < QUEUE_DEPTH);
            check_value("nearly_full", nearly_full, cnt == QUEUE_DEPTH - 1);
            check_value("space_ok", space_ok, cnt <= QUEUE_DEPTH - 2);
            check_head();
            // flush wins over both strobes
            if (fl) begin
                model_q.delete();
            end else begin
                if (exp_pop) begin
                    void'(model_q.pop_front());
                end
                if (exp_push) begin
                    model_q.push_back(pkt);
                end
            end
        end
        @(posedge clk);
        #1;
        apply_inputs(1'b0, 1'b0, 1'b0, '0);
        $display("Done: no errors");
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout: the table did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   flush,
    input  wire logic                   fifo_readygo,
    input  wire logic                   fifo_ready,
    input  wire fetch_pkg::flag2_t      priv_flag,
    input  wire fetch_pkg::flag2_t      branch_flag,
    input  wire fetch_pkg::word_t       if1_inst0,
    input  wire fetch_pkg::word_t       if1_inst1,
    input  wire fetch_pkg::word_t       if1_pc,
    input  wire fetch_pkg::word_t       if1_pc_next,
    input  wire logic                   if1_pc_taken,
    input  wire fetch_pkg::word_t       if1_badv,
    input  wire fetch_pkg::excp_code_t  if1_exception,
    input  wire fetch_pkg::flag2_t      if1_excp_flag,
    output logic                        write_en,
    output logic                        pop_en,
    output logic                        fifo_allowin,
    output logic                        fifo_valid,
    output logic                        nearly_full,
    output logic                        space_ok,
    output fetch_pkg::word_t            fifo_inst0,
    output fetch_pkg::word_t            fifo_inst1,
    output fetch_pkg::word_t            fifo_pc,
    output fetch_pkg::word_t            fifo_pc_add,
    output fetch_pkg::word_t            fifo_pc_next,
    output fetch_pkg::word_t            fifo_badv,
    output logic                        fifo_pc_taken,
    output fetch_pkg::excp_code_t       fifo_exception,
    output fetch_pkg::flag2_t           fifo_excp_flag,
    output fetch_pkg::flag2_t           fifo_priv_flag,
    output fetch_pkg::flag2_t           fifo_branch_flag
);

    import fetch_pkg::*;

    inst_pair_t inst_din;
    inst_pair_t inst_dout;
    fetch_tag_t tag_din;
    fetch_tag_t tag_dout;
    logic       inst_full;
    logic       inst_empty;
    logic       inst_nearly_full;
    logic       tag_full;
    logic       tag_empty;

    assign inst_din = {if1_inst1, if1_inst0};

    // order must match the TAG_*_LSB layout in the package
    assign tag_din = {
        if1_pc_next,
        if1_pc,
        if1_badv,
        if1_pc_taken,
        branch_flag,
        priv_flag,
        if1_excp_flag,
        if1_exception
    };

    fetch_fifo #(
        .DATA_WIDTH   (INST_W)
    ) inst_queue_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .push         (write_en),
        .pop          (pop_en),
        .din          (inst_din),
        .dout         (inst_dout),
        .full         (inst_full),
        .empty        (inst_empty),
        .nearly_full  (inst_nearly_full),
        // no consumer for the low-water mark yet
        .nearly_empty ()
    );

    // tag queue levels are only cross-checked, never used for control
    fetch_fifo #(
        .DATA_WIDTH   (TAG_W)
    ) tag_queue_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .push         (write_en),
        .pop          (pop_en),
        .din          (tag_din),
        .dout         (tag_dout),
        .full         (tag_full),
        .empty        (tag_empty),
        .nearly_full  (),
        .nearly_empty ()
    );

    fetch_buf_ctrl ctrl_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .fifo_readygo     (fifo_readygo),
        .fifo_ready       (fifo_ready),
        .inst_dout        (inst_dout),
        .tag_dout         (tag_dout),
        .inst_full        (inst_full),
        .inst_empty       (inst_empty),
        .inst_nearly_full (inst_nearly_full),
        .tag_full         (tag_full),
        .tag_empty        (tag_empty),
        .write_en         (write_en),
        .pop_en           (pop_en),
        .fifo_allowin     (fifo_allowin),
        .fifo_valid       (fifo_valid),
        .nearly_full      (nearly_full),
        .space_ok         (space_ok),
        .fifo_inst0       (fifo_inst0),
        .fifo_inst1       (fifo_inst1),
        .fifo_pc          (fifo_pc),
        .fifo_pc_add      (fifo_pc_add),
        .fifo_pc_next     (fifo_pc_next),
        .fifo_badv        (fifo_badv),
        .fifo_pc_taken    (fifo_pc_taken),
        .fifo_exception   (fifo_exception),
        .fifo_excp_flag   (fifo_excp_flag),
        .fifo_priv_flag   (fifo_priv_flag),
        .fifo_branch_flag (fifo_branch_flag)
    );

endmodule

`default_nettype wire

//--- hdl/fetch_buf_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buf_ctrl (
    // clock and reset feed the assertions only
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   fifo_readygo,
    input  wire logic                   fifo_ready,
    input  wire fetch_pkg::inst_pair_t  inst_dout,
    input  wire fetch_pkg::fetch_tag_t  tag_dout,
    input  wire logic                   inst_full,
    input  wire logic                   inst_empty,
    input  wire logic                   inst_nearly_full,
    input  wire logic                   tag_full,
    input  wire logic                   tag_empty,
    output logic                        write_en,
    output logic                        pop_en,
    output logic                        fifo_allowin,
    output logic                        fifo_valid,
    output logic                        nearly_full,
    output logic                        space_ok,
    output fetch_pkg::word_t            fifo_inst0,
    output fetch_pkg::word_t            fifo_inst1,
    output fetch_pkg::word_t            fifo_pc,
    output fetch_pkg::word_t            fifo_pc_add,
    output fetch_pkg::word_t            fifo_pc_next,
    output fetch_pkg::word_t            fifo_badv,
    output logic                        fifo_pc_taken,
    output fetch_pkg::excp_code_t       fifo_exception,
    output fetch_pkg::flag2_t           fifo_excp_flag,
    output fetch_pkg::flag2_t           fifo_priv_flag,
    output fetch_pkg::flag2_t           fifo_branch_flag
);

    import fetch_pkg::*;

    // shared strobes for both queues
    assign write_en = fifo_readygo && !inst_full;
    assign pop_en   = fifo_ready && !inst_empty;

    // status levels, the instruction queue stands for both
    assign fifo_allowin = !inst_full;
    assign fifo_valid   = !inst_empty;
    assign nearly_full  = inst_nearly_full;
    // count of two or less
    assign space_ok     = !inst_full && !inst_nearly_full;

    // head packet, or a nop packet at the reset pc when empty
    always_comb begin
        if (fifo_valid) begin
            fifo_inst0       = inst_dout[0 +: WORD_W];
            fifo_inst1       = inst_dout[WORD_W +: WORD_W];
            fifo_pc          = tag_dout[TAG_PC_LSB +: WORD_W];
            fifo_pc_next     = tag_dout[TAG_PCN_LSB +: WORD_W];
            fifo_badv        = tag_dout[TAG_BADV_LSB +: WORD_W];
            fifo_pc_taken    = tag_dout[TAG_TAKEN_BIT];
            fifo_exception   = tag_dout[TAG_EXCP_LSB +: EXCP_W];
            fifo_excp_flag   = tag_dout[TAG_XFLAG_LSB +: FLAG_W];
            fifo_priv_flag   = tag_dout[TAG_PRIV_LSB +: FLAG_W];
            fifo_branch_flag = tag_dout[TAG_BR_LSB +: FLAG_W];
        end else begin
            fifo_inst0       = INST_NOP;
            fifo_inst1       = INST_NOP;
            fifo_pc          = PC_RESET;
            // nop pair covers two slots
            fifo_pc_next     = PC_RESET + word_t'(8);
            fifo_badv        = PC_RESET;
            fifo_pc_taken    = 1'b0;
            fifo_exception   = '0;
            fifo_excp_flag   = '0;
            fifo_priv_flag   = '0;
            fifo_branch_flag = '0;
        end
    end

    // pc of the second slot
    assign fifo_pc_add = fifo_pc + word_t'(4);

    // both queues see identical strobes, so they must track each other
    a_queues_agree: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tag_full == inst_full) && (tag_empty == inst_empty)
    ) else $error("fetch_buf_ctrl: instruction and tag queues disagree");

    // the buffer only becomes valid through a push
    a_valid_needs_push: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(fifo_valid) |-> $past(write_en)
    ) else $error("fetch_buf_ctrl: valid rose without a push");

    // same for reaching full
    a_full_needs_push: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(inst_full) |-> $past(write_en) && !$past(pop_en)
    ) else $error("fetch_buf_ctrl: full rose without a net push");

endmodule

`default_nettype wire

//--- hdl/fetch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo #(
    parameter int DATA_WIDTH = fetch_pkg::INST_W
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  flush,
    input  wire logic                  push,
    input  wire logic                  pop,
    input  wire logic [DATA_WIDTH-1:0] din,
    output logic      [DATA_WIDTH-1:0] dout,
    output logic                       full,
    output logic                       empty,
    output logic                       nearly_full,
    output logic                       nearly_empty
);

    import fetch_pkg::*;

    logic [DATA_WIDTH-1:0]  mem [FETCH_DEPTH];
    logic [FETCH_PTR_W-1:0] wr_ptr;
    logic [FETCH_PTR_W-1:0] rd_ptr;
    fifo_cnt_t              cnt;

    // storage, written only while not flushing
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + FETCH_PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + FETCH_PTR_W'(1);
            end
        end
    end

    // occupancy count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (flush) begin
            cnt <= '0;
        end else begin
            case ({push, pop})
                2'b10: begin
                    cnt <= cnt + fifo_cnt_t'(1);
                end
                2'b01: begin
                    cnt <= cnt - fifo_cnt_t'(1);
                end
                default: begin
                    // idle, or push and pop together
                    cnt <= cnt;
                end
            endcase
        end
    end

    // show-ahead read of the head entry
    assign dout = mem[rd_ptr];

    // flags straight from the count
    assign full         = (cnt == fifo_cnt_t'(FETCH_DEPTH));
    assign empty        = (cnt == fifo_cnt_t'(0));
    assign nearly_full  = (cnt == fifo_cnt_t'(FETCH_DEPTH - 1));
    assign nearly_empty = (cnt == fifo_cnt_t'(1));

    // strobes are qualified upstream, so these must never fire
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> !full
    ) else $error("fetch_fifo: push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> !empty
    ) else $error("fetch_fifo: pop while empty");

    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt <= fifo_cnt_t'(FETCH_DEPTH)
    ) else $error("fetch_fifo: count above depth");

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // basic field widths
    localparam int WORD_W = 32;
    localparam int EXCP_W = 7;
    localparam int FLAG_W = 2;

    // queue geometry
    localparam int FETCH_DEPTH = 4;
    localparam int FETCH_PTR_W = 2;

    // instruction queue entry holds two words, inst1 on top
    localparam int INST_W = 2 * WORD_W;

    // tag entry layout, low to high
    localparam int TAG_EXCP_LSB  = 0;
    localparam int TAG_XFLAG_LSB = TAG_EXCP_LSB + EXCP_W;
    localparam int TAG_PRIV_LSB  = TAG_XFLAG_LSB + FLAG_W;
    localparam int TAG_BR_LSB    = TAG_PRIV_LSB + FLAG_W;
    localparam int TAG_TAKEN_BIT = TAG_BR_LSB + FLAG_W;
    localparam int TAG_BADV_LSB  = TAG_TAKEN_BIT + 1;
    localparam int TAG_PC_LSB    = TAG_BADV_LSB + WORD_W;
    localparam int TAG_PCN_LSB   = TAG_PC_LSB + WORD_W;

    // 110 bits in total
    localparam int TAG_W = TAG_PCN_LSB + WORD_W;

    // pc, address or instruction
    typedef logic [WORD_W-1:0] word_t;

    typedef logic [INST_W-1:0] inst_pair_t;

    typedef logic [TAG_W-1:0] fetch_tag_t;

    typedef logic [EXCP_W-1:0] excp_code_t;

    // excp, priv and branch flags
    typedef logic [FLAG_W-1:0] flag2_t;

    // occupancy, needs to reach FETCH_DEPTH itself
    typedef logic [FETCH_PTR_W:0] fifo_cnt_t;

    // core comes out of reset here
    localparam word_t PC_RESET = 32'h1c00_0000;

    // andi r0, r0, 0
    localparam word_t INST_NOP = 32'h0340_0000;

endpackage

`default_nettype wire
